/* logic/lsu_pkg.sv */
package lsu_pkg;

    // load width codes (funct3 of the RV32I load opcode)
    localparam logic [2:0] funct3_lb  = 3'd0;   // signed byte
    localparam logic [2:0] funct3_lh  = 3'd1;   // signed halfword
    localparam logic [2:0] funct3_lw  = 3'd2;   // full word
    localparam logic [2:0] funct3_lbu = 3'd4;   // unsigned byte
    localparam logic [2:0] funct3_lhu = 3'd5;   // unsigned halfword

    // store width codes (funct3 of the RV32I store opcode)
    localparam logic [2:0] funct3_sb  = 3'd0;   // byte
    localparam logic [2:0] funct3_sh  = 3'd1;   // halfword
    localparam logic [2:0] funct3_sw  = 3'd2;   // word

    // One memory word. Lane n of the byte view sits at bits 8n+7:8n,
    // halfword n sits at bits 16n+15:16n, little endian like the core.
    typedef union packed {
        logic [3:0][7:0]  bytes;    // lane view
        logic [1:0][15:0] halves;   // halfword view
    } mem_word_t;

endpackage

/* logic/mem_port_if.sv */
interface mem_port_if #(
    parameter int addr_width = 6
);
    import lsu_pkg::*;

    logic                  req;         // one-cycle request strobe
    logic                  we;          // masked write enable
    logic [addr_width-1:0] word_addr;
    logic [3:0]            byte_mask;   // one bit per lane
    mem_word_t             wdata;       // replicated store data
    logic [2:0]            funct3;      // width code, kept for the aligner
    logic [1:0]            lane;        // address bits 1:0
    logic                  is_load;
    logic                  fault;       // misaligned or unknown store
    mem_word_t             rdata;       // registered read word

    modport producer (
        output req, we, word_addr, byte_mask, wdata, funct3, lane, is_load, fault
    );

    modport buffer (
        input  req, we, word_addr, byte_mask, wdata,
        output rdata
    );

    modport consumer (
        input funct3, lane, is_load, fault, req, rdata
    );

endinterface

/* logic/store_formatter.sv */
module store_formatter #(
    parameter int addr_width = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [2:0]            funct3,
    input  logic [addr_width+1:0] address,
    input  logic [31:0]           store_data,
    mem_port_if.producer          port
);
    import lsu_pkg::*;

    logic [3:0]  mask_next;
    logic [31:0] data_next;
    logic        store_bad;

    // lane replication and write mask for a store
    always_comb begin
        mask_next = 4'b0000;
        data_next = store_data;
        case (funct3)
            funct3_sb: begin
                data_next = {4{store_data[7:0]}};
                mask_next = 4'b0001 << address[1:0];    // one bit per lane
            end
            funct3_sh: begin
                data_next = {2{store_data[15:0]}};
                if (!address[0]) begin
                    mask_next = address[1] ? 4'b1100 : 4'b0011;
                end
            end
            funct3_sw: begin
                if (address[1:0] == 2'b00) begin
                    mask_next = 4'b1111;
                end
            end
            default: begin
                data_next = 32'h0000_0000;  // unknown width, nothing written
            end
        endcase
    end

    assign store_bad = (mask_next == 4'b0000);  // empty mask means a faulted store

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            port.req     <= 1'b0;
            port.we      <= 1'b0;
            port.is_load <= 1'b0;
            port.fault   <= 1'b0;
        end else begin
            port.req     <= mem_read | mem_write;
            port.we      <= mem_write & ~store_bad;
            port.is_load <= mem_read;
            port.fault   <= mem_write & store_bad;
        end
    end

    // payload, only meaningful alongside req
    always_ff @(posedge clk) begin
        if (mem_read || mem_write) begin
            port.word_addr <= address[addr_width+1:2];
            port.lane      <= address[1:0];
            port.funct3    <= funct3;
            port.byte_mask <= mem_write ? mask_next : 4'b0000;
            port.wdata     <= data_next;
        end
    end

endmodule

/* logic/data_memory.sv */
module data_memory #(
    parameter int addr_width = 6
) (
    input  logic       clk,
    mem_port_if.buffer port
);
    import lsu_pkg::*;

    localparam int depth = 2 ** addr_width;

    mem_word_t mem [depth];     // contents undefined until written

    // byte-masked write, one lane at a time
    always_ff @(posedge clk) begin
        if (port.req && port.we) begin
            for (int i = 0; i < 4; i++) begin
                if (port.byte_mask[i]) begin
                    mem[port.word_addr].bytes[i] <= port.wdata.bytes[i];
                end
            end
        end
    end

    // Whole word read on every request, stores included. A store in the
    // previous cycle has already landed, so a load right behind it sees
    // the new bytes.
    always_ff @(posedge clk) begin
        if (port.req) begin
            port.rdata <= mem[port.word_addr];
        end
    end

endmodule

/* logic/load_aligner.sv */
module load_aligner (
    input  logic           clk,
    input  logic           rst_n,
    mem_port_if.consumer   port,
    output logic           load_valid,
    output logic [31:0]    load_data,
    output logic           store_done,
    output logic           store_fault
);
    import lsu_pkg::*;

    logic        req_q;         // request now has rdata
    logic        is_load_q;
    logic        fault_q;
    logic [1:0]  lane_q;
    logic [2:0]  funct3_q;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] load_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= port.req;
        end
    end

    // side info follows the request into the rdata cycle
    always_ff @(posedge clk) begin
        if (port.req) begin
            is_load_q <= port.is_load;
            fault_q   <= port.fault;
            lane_q    <= port.lane;
            funct3_q  <= port.funct3;
        end
    end

    assign byte_sel = port.rdata.bytes[lane_q];
    assign half_sel = port.rdata.halves[lane_q[1]];    // bit 0 ignored for halfwords

    always_comb begin
        case (funct3_q)
            funct3_lb:  load_next = {{24{byte_sel[7]}}, byte_sel};
            funct3_lbu: load_next = {24'h00_0000, byte_sel};
            funct3_lh:  load_next = {{16{half_sel[15]}}, half_sel};
            funct3_lhu: load_next = {16'h0000, half_sel};
            funct3_lw:  load_next = port.rdata;
            default:    load_next = 32'h0000_0000;  // unknown width reads as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_valid  <= 1'b0;
            store_done  <= 1'b0;
            store_fault <= 1'b0;
        end else begin
            load_valid  <= req_q & is_load_q;
            store_done  <= req_q & ~is_load_q & ~fault_q;
            store_fault <= req_q & ~is_load_q & fault_q;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q && is_load_q) begin
            load_data <= load_next;     // held until the next load
        end
    end

endmodule

/* logic/lsu_top.sv */
module lsu_top #(
    parameter int addr_width = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [2:0]            funct3,
    input  logic [addr_width+1:0] address,     // byte address
    input  logic [31:0]           store_data,
    output logic                  load_valid,
    output logic [31:0]           load_data,
    output logic                  store_done,
    output logic                  store_fault
);

    mem_port_if #(
        .addr_width (addr_width)
    ) mem_port ();

    store_formatter #(
        .addr_width (addr_width)
    ) store_formatter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .funct3     (funct3),
        .address    (address),
        .store_data (store_data),
        .port       (mem_port.producer)
    );

    data_memory #(
        .addr_width (addr_width)
    ) data_memory_i (
        .clk  (clk),
        .port (mem_port.buffer)
    );

    load_aligner load_aligner_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .port        (mem_port.consumer),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .store_done  (store_done),
        .store_fault (store_fault)
    );

endmodule

/* tb/lsu_assert.sv */
module lsu_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       req,
    input logic       we,
    input logic [3:0] byte_mask,
    input logic       fault
);

    // a write only ever rides on a request
    we_needs_req: assert property (@(posedge clk) disable iff (!rst_n) we |-> req)
        else $error("memory write enable high without a request");

    // an accepted store always has at least one lane enabled
    mask_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (byte_mask != 4'b0000))
        else $error("memory write enable high with an empty byte mask");

    no_write_on_fault: assert property (@(posedge clk) disable iff (!rst_n)
        !(fault && we))
        else $error("faulted store reached the memory as a write");

endmodule

// memory port checks, on the interface instance in the top level
bind lsu_top lsu_assert lsu_assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (mem_port.req),
    .we        (mem_port.we),
    .byte_mask (mem_port.byte_mask),
    .fault     (mem_port.fault)
);

/* tb/lsu_tb.sv */
module lsu_tb;
    import lsu_pkg::*;

    localparam int addr_width = 6;
    localparam int kind_data  = 0;     // load result expected
    localparam int kind_done  = 1;
    localparam int kind_fault = 2;

    typedef logic [addr_width+1:0] addr_t;

    logic        clk;
    logic        rst_n;
    logic        mem_read;
    logic        mem_write;
    logic [2:0]  funct3;
    addr_t       address;
    logic [31:0] store_data;
    logic        load_valid;
    logic [31:0] load_data;
    logic        store_done;
    logic        store_fault;

    // stimulus table, one entry per request
    string       t_name[$];
    bit          t_wr[$];
    logic [2:0]  t_f3[$];
    addr_t       t_addr[$];
    logic [31:0] t_data[$];

    // results still in flight, oldest first
    string       exp_name[$];
    int          exp_kind[$];
    logic [31:0] exp_data[$];

    logic [7:0]  model_mem [4 * 2 ** addr_width];  // byte-addressed reference
    int          errors;
    int          checks;

    lsu_top #(
        .addr_width (addr_width)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .funct3      (funct3),
        .address     (address),
        .store_data  (store_data),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .store_done  (store_done),
        .store_fault (store_fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [3:0] store_mask(input logic [2:0] f3, input logic [1:0] lane);
        logic [3:0] mask;
        mask = 4'b0000;
        case (f3)
            funct3_sb: mask[lane] = 1'b1;
            funct3_sh: begin
                if (lane == 2'd0) mask = 4'b0011;
                else if (lane == 2'd2) mask = 4'b1100;     // odd lanes misaligned
            end
            funct3_sw: begin
                if (lane == 2'd0) mask = 4'b1111;
            end
            default: mask = 4'b0000;
        endcase
        return mask;
    endfunction

    function automatic void apply_store(input logic [2:0] f3, input addr_t addr,
                                        input logic [31:0] data, input logic [3:0] mask);
        logic [1:0] li;
        logic [7:0] value;
        for (int i = 0; i < 4; i++) begin
            li = 2'(i);
            if (f3 == funct3_sb) value = data[7:0];
            else if (f3 == funct3_sh) value = li[0] ? data[15:8] : data[7:0];
            else value = data[8*i +: 8];
            if (mask[i]) model_mem[{addr[addr_width+1:2], li}] = value;
        end
    endfunction

    function automatic logic [31:0] load_expect(input logic [2:0] f3, input addr_t addr);
        logic [addr_width-1:0] w;
        logic [7:0]            b;
        logic [15:0]           h;
        w = addr[addr_width+1:2];
        b = model_mem[addr];
        h = {model_mem[{w, addr[1], 1'b1}], model_mem[{w, addr[1], 1'b0}]};
        case (f3)
            funct3_lb:  return {{24{b[7]}}, b};
            funct3_lbu: return {24'h00_0000, b};
            funct3_lh:  return {{16{h[15]}}, h};
            funct3_lhu: return {16'h0000, h};
            funct3_lw:  return {model_mem[{w, 2'd3}], model_mem[{w, 2'd2}],
                                model_mem[{w, 2'd1}], model_mem[{w, 2'd0}]};
            default:    return 32'h0000_0000;
        endcase
    endfunction

    task automatic add_entry(input string name, input bit wr, input logic [2:0] f3,
                             input addr_t addr, input logic [31:0] data);
        t_name.push_back(name);
        t_wr.push_back(wr);
        t_f3.push_back(f3);
        t_addr.push_back(addr);
        t_data.push_back(data);
    endtask

    task automatic build_table();
        addr_t a;
        add_entry("sw_random", 1'b1, funct3_sw, 8'h10, $urandom());
        add_entry("lw_random", 1'b0, funct3_lw, 8'h10, 32'h0);
        // byte stores over a known word
        add_entry("sw_known", 1'b1, funct3_sw, 8'h20, 32'h1122_3344);
        for (int l = 0; l < 4; l++) begin
            a = addr_t'(32'h20 + l);
            add_entry($sformatf("sb_lane%0d", l), 1'b1, funct3_sb, a, $urandom());
            add_entry($sformatf("lw_after_sb%0d", l), 1'b0, funct3_lw, 8'h20, 32'h0);
        end
        add_entry("sw_bit7_set", 1'b1, funct3_sw, 8'h30, 32'h8a9c_f081);
        add_entry("sw_bit7_clear", 1'b1, funct3_sw, 8'h34, 32'h7a1c_7001);
        for (int w = 0; w < 2; w++) begin
            for (int l = 0; l < 4; l++) begin
                a = addr_t'(32'h30 + 4 * w + l);
                add_entry($sformatf("lb_w%0d_lane%0d", w, l), 1'b0, funct3_lb, a, 32'h0);
                add_entry($sformatf("lbu_w%0d_lane%0d", w, l), 1'b0, funct3_lbu, a, 32'h0);
            end
        end
        add_entry("sw_halves", 1'b1, funct3_sw, 8'h40, 32'h8001_7ffe);
        for (int l = 0; l < 4; l += 2) begin
            a = addr_t'(32'h40 + l);
            add_entry($sformatf("lh_lane%0d", l), 1'b0, funct3_lh, a, 32'h0);
            add_entry($sformatf("lhu_lane%0d", l), 1'b0, funct3_lhu, a, 32'h0);
        end
        // back to back store and load of one word
        add_entry("sh_then_load", 1'b1, funct3_sh, 8'h42, $urandom());
        add_entry("lh_after_sh", 1'b0, funct3_lh, 8'h42, 32'h0);
        add_entry("sb_then_load", 1'b1, funct3_sb, 8'h41, $urandom());
        add_entry("lbu_after_sb", 1'b0, funct3_lbu, 8'h41, 32'h0);
        add_entry("sw_fault_base", 1'b1, funct3_sw, 8'h50, 32'hdead_beef);
        add_entry("sh_lane1", 1'b1, funct3_sh, 8'h51, $urandom());
        add_entry("sh_lane3", 1'b1, funct3_sh, 8'h53, $urandom());
        add_entry("sw_lane1", 1'b1, funct3_sw, 8'h51, $urandom());
        add_entry("sw_lane2", 1'b1, funct3_sw, 8'h52, $urandom());
        add_entry("sw_lane3", 1'b1, funct3_sw, 8'h53, $urandom());
        add_entry("store_width3", 1'b1, 3'd3, 8'h50, $urandom());
        add_entry("store_width7", 1'b1, 3'd7, 8'h50, $urandom());
        add_entry("lw_after_faults", 1'b0, funct3_lw, 8'h50, 32'h0);
        add_entry("load_width3", 1'b0, 3'd3, 8'h50, 32'h0);
        add_entry("load_width6", 1'b0, 3'd6, 8'h50, 32'h0);
        add_entry("load_width7", 1'b0, 3'd7, 8'h50, 32'h0);
    endtask

    task automatic issue_all();
        logic [3:0] mask;
        for (int i = 0; i < t_name.size(); i++) begin
            @(posedge clk);
            #1;
            mem_read   = ~t_wr[i];
            mem_write  = t_wr[i];
            funct3     = t_f3[i];
            address    = t_addr[i];
            store_data = t_data[i];
            exp_name.push_back(t_name[i]);
            if (t_wr[i]) begin
                mask = store_mask(t_f3[i], t_addr[i][1:0]);
                apply_store(t_f3[i], t_addr[i], t_data[i], mask);   // model sees it at issue
                exp_kind.push_back((mask == 4'b0000) ? kind_fault : kind_done);
                exp_data.push_back(32'h0);
            end else begin
                exp_kind.push_back(kind_data);
                exp_data.push_back(load_expect(t_f3[i], t_addr[i]));
            end
        end
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic wait_pulse(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 10) begin
            @(negedge clk);     // outputs settled mid-cycle
            if (load_valid || store_done || store_fault) seen = 1'b1;
            cycles++;
        end
    endtask

    task automatic check_result(input string name, input int kind, input logic [31:0] data);
        logic [2:0] exp_flags;
        logic [2:0] got_flags;
        exp_flags = (kind == kind_data) ? 3'b100 : (kind == kind_done) ? 3'b010 : 3'b001;
        got_flags = {load_valid, store_done, store_fault};
        checks++;
        assert (got_flags === exp_flags) else begin
            errors++;
            $display("mismatch %s: expected valid/done/fault %b, got %b",
                     name, exp_flags, got_flags);
        end
        if (kind == kind_data) begin
            assert (load_data === data) else begin
                errors++;
                $display("mismatch %s: expected data %h, got %h", name, data, load_data);
            end
        end
    endtask

    task automatic check_all();
        bit seen;
        bit stop;
        stop = 1'b0;
        for (int i = 0; i < t_name.size() && !stop; i++) begin
            wait_pulse(seen);
            if (!seen) begin
                errors++;
                $display("timeout: no result pulse within 10 cycles for %s", t_name[i]);
                stop = 1'b1;
            end else if (exp_name.size() == 0) begin
                errors++;
                $display("result pulse arrived with no request outstanding");
                stop = 1'b1;
            end else begin
                check_result(exp_name.pop_front(), exp_kind.pop_front(),
                             exp_data.pop_front());
            end
        end
    endtask

    initial begin
        void'($urandom(32'h4cca_465f));
        rst_n      = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        funct3     = 3'd0;
        address    = '0;
        store_data = 32'h0;
        errors     = 0;
        checks     = 0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            issue_all();
            check_all();
        join
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
logic/lsu_pkg.sv
logic/mem_port_if.sv
logic/store_formatter.sv
logic/data_memory.sv
logic/load_aligner.sv
logic/lsu_top.sv
tb/lsu_assert.sv
tb/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
